//--- design/coreExecPkg.sv
package coreExecPkg;

	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int regIdWidth = 4;

	// opcode map, every other value is illegal.
	localparam logic [3:0] opAdd = 4'd0;
	localparam logic [3:0] opSub = 4'd1;
	localparam logic [3:0] opXor = 4'd2;
	localparam logic [3:0] opSll = 4'd4;
	localparam logic [3:0] opSra = 4'd5;
	localparam logic [3:0] opRor = 4'd6;
	localparam logic [3:0] opLlb = 4'd10;
	localparam logic [3:0] opLhb = 4'd11;

	typedef struct packed {
		logic [3:0] opcode;
		logic [regIdWidth-1:0] rd;
		logic [regIdWidth-1:0] rs;
		logic [regIdWidth-1:0] rt; // shift amount for shifts and rotate.
	} rTypeFields_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [regIdWidth-1:0] rd;
		logic [7:0] imm8;
	} immTypeFields_t;

	// the same 16-bit word seen as register or immediate format.
	typedef union packed {
		rTypeFields_t rType;
		immTypeFields_t immType;
	} instrWord_t;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluXor,
		aluSll,
		aluSra,
		aluRor,
		aluLlb,
		aluLhb
	} aluOp_t;

endpackage

//--- design/regFileIf.sv
`timescale 1ns/1ps

interface regFileIf;

	logic [coreExecPkg::regIdWidth-1:0] srcReg1;
	logic [coreExecPkg::regIdWidth-1:0] srcReg2;
	logic [coreExecPkg::regIdWidth-1:0] dstReg;
	logic writeReg; // one-cycle strobe, lands at the next edge.
	logic [coreExecPkg::dataWidth-1:0] dstData;
	logic [coreExecPkg::dataWidth-1:0] srcData1;
	logic [coreExecPkg::dataWidth-1:0] srcData2;

	modport fileSide (
		input srcReg1, srcReg2, dstReg, writeReg, dstData,
		output srcData1, srcData2
	);

	modport issueSide (
		output srcReg1, srcReg2, dstReg, writeReg, dstData,
		input srcData1, srcData2
	);

endinterface

//--- design/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic reset,
	regFileIf.fileSide rf
);

	logic [coreExecPkg::dataWidth-1:0] regs [coreExecPkg::regCount];
	logic [coreExecPkg::regCount-1:0] wordLine;

	// one enable per register, all low without a write strobe.
	always_comb begin
		wordLine = '0;
		if (rf.writeReg) begin
			wordLine[rf.dstReg] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < coreExecPkg::regCount; i++) begin
			if (reset) begin
				regs[i] <= '0;
			end else if (wordLine[i]) begin
				regs[i] <= rf.dstData;
			end
		end
	end

	// reads see the stored value only, no write bypass.
	assign rf.srcData1 = regs[rf.srcReg1];
	assign rf.srcData2 = regs[rf.srcReg2];

	property writeKnown;
		@(posedge clk) disable iff (reset)
			rf.writeReg |-> !$isunknown({rf.dstReg, rf.dstData});
	endproperty

	writeKnownCheck: assert property (writeKnown)
		else $error("register write with unknown id or data");

endmodule

//--- design/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input coreExecPkg::aluOp_t aluOp,
	input logic [coreExecPkg::dataWidth-1:0] operandA,
	input logic [coreExecPkg::dataWidth-1:0] operandB,
	input logic [3:0] shiftAmount,
	input logic [7:0] imm8,
	output logic [coreExecPkg::dataWidth-1:0] aluResult,
	output logic saturated,
	output logic resultZero
);

	localparam int msb = coreExecPkg::dataWidth - 1;

	logic isSub;
	logic [coreExecPkg::dataWidth-1:0] bSel;
	logic [coreExecPkg::dataWidth-1:0] rawSum;
	logic [coreExecPkg::dataWidth-1:0] satValue;
	logic [2*coreExecPkg::dataWidth-1:0] rotWide;
	logic sumOverflow;

	// subtract as a plus not b plus one.
	assign isSub = (aluOp == coreExecPkg::aluSub);
	assign bSel = isSub ? ~operandB : operandB;
	assign rawSum = operandA + bSel + {{(coreExecPkg::dataWidth-1){1'b0}}, isSub};

	// same-sign inputs with a flipped result sign overflowed.
	assign sumOverflow = (operandA[msb] == bSel[msb]) && (rawSum[msb] != operandA[msb]);
	assign satValue = operandA[msb] ? 16'h8000 : 16'h7fff;

	assign rotWide = {operandA, operandA} >> shiftAmount;

	always_comb begin
		aluResult = '0;
		saturated = 1'b0;
		case (aluOp)
			coreExecPkg::aluAdd,
			coreExecPkg::aluSub: begin
				aluResult = sumOverflow ? satValue : rawSum;
				saturated = sumOverflow;
			end
			coreExecPkg::aluXor: begin
				aluResult = operandA ^ operandB;
			end
			coreExecPkg::aluSll: begin
				aluResult = operandA << shiftAmount;
			end
			coreExecPkg::aluSra: begin
				aluResult = $signed(operandA) >>> shiftAmount; // sign fills from the top.
			end
			coreExecPkg::aluRor: begin
				aluResult = rotWide[coreExecPkg::dataWidth-1:0];
			end
			coreExecPkg::aluLlb: begin
				aluResult = {operandA[msb:8], imm8}; // keep the high byte.
			end
			coreExecPkg::aluLhb: begin
				aluResult = {imm8, operandA[7:0]}; // keep the low byte.
			end
			default: begin
				aluResult = '0;
			end
		endcase
	end

	assign resultZero = (aluResult == '0);

endmodule

//--- design/issueStage.sv
`timescale 1ns/1ps

module issueStage (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input coreExecPkg::instrWord_t instr,
	regFileIf.issueSide rf,
	output coreExecPkg::aluOp_t aluOp,
	output logic [coreExecPkg::dataWidth-1:0] operandA,
	output logic [coreExecPkg::dataWidth-1:0] operandB,
	output logic [3:0] shiftAmount,
	output logic [7:0] imm8,
	input logic [coreExecPkg::dataWidth-1:0] aluResult,
	input logic saturated,
	input logic resultZero,
	output logic resultValid,
	output logic [coreExecPkg::dataWidth-1:0] result,
	output logic [coreExecPkg::regIdWidth-1:0] resultDst,
	output logic illegal,
	output logic flagZero,
	output logic flagOverflow,
	output logic flagNegative
);

	coreExecPkg::instrWord_t instrQ;
	logic validQ;
	logic isLegal;
	logic isImm;
	logic isArith;
	logic [coreExecPkg::regIdWidth-1:0] dstSel;

	always_comb begin
		isLegal = 1'b1;
		aluOp = coreExecPkg::aluAdd;
		case (instrQ.rType.opcode)
			coreExecPkg::opAdd: aluOp = coreExecPkg::aluAdd;
			coreExecPkg::opSub: aluOp = coreExecPkg::aluSub;
			coreExecPkg::opXor: aluOp = coreExecPkg::aluXor;
			coreExecPkg::opSll: aluOp = coreExecPkg::aluSll;
			coreExecPkg::opSra: aluOp = coreExecPkg::aluSra;
			coreExecPkg::opRor: aluOp = coreExecPkg::aluRor;
			coreExecPkg::opLlb: aluOp = coreExecPkg::aluLlb;
			coreExecPkg::opLhb: aluOp = coreExecPkg::aluLhb;
			default: isLegal = 1'b0;
		endcase
	end

	assign isImm = (aluOp == coreExecPkg::aluLlb) || (aluOp == coreExecPkg::aluLhb);
	assign isArith = (aluOp == coreExecPkg::aluAdd) || (aluOp == coreExecPkg::aluSub);
	assign dstSel = instrQ.rType.rd;

	// byte loads read rd so the other byte survives.
	assign rf.srcReg1 = isImm ? instrQ.immType.rd : instrQ.rType.rs;
	assign rf.srcReg2 = instrQ.rType.rt;
	assign operandA = rf.srcData1;
	assign operandB = rf.srcData2;
	assign shiftAmount = instrQ.rType.rt;
	assign imm8 = instrQ.immType.imm8;

	// write lands at the same edge that reports the result.
	assign rf.writeReg = validQ && isLegal;
	assign rf.dstReg = dstSel;
	assign rf.dstData = aluResult;

	always_ff @(posedge clk) begin
		if (reset) begin
			validQ <= 1'b0;
			resultValid <= 1'b0;
			illegal <= 1'b0;
			flagZero <= 1'b0;
			flagOverflow <= 1'b0;
			flagNegative <= 1'b0;
		end else begin
			validQ <= instrValid;
			resultValid <= validQ;
			illegal <= validQ && !isLegal;
			if (validQ && isLegal && !isImm) begin // byte loads keep the flags.
				flagZero <= resultZero;
				flagOverflow <= isArith && saturated;
				flagNegative <= isArith && aluResult[coreExecPkg::dataWidth-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin
			instrQ <= instr;
		end
		if (validQ) begin
			result <= isLegal ? aluResult : '0;
			resultDst <= dstSel;
		end
	end

	property resultPairNeedsStrobes;
		@(posedge clk) disable iff (reset)
			resultValid && $past(resultValid) |-> $past(instrValid, 2) && $past(instrValid, 3);
	endproperty

	resultPairCheck: assert property (resultPairNeedsStrobes)
		else $error("back-to-back results without back-to-back instructions");

endmodule

//--- design/coreExec.sv
`timescale 1ns/1ps

module coreExec (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input logic [coreExecPkg::dataWidth-1:0] instr,
	output logic resultValid,
	output logic [coreExecPkg::dataWidth-1:0] result,
	output logic [coreExecPkg::regIdWidth-1:0] resultDst,
	output logic illegal,
	output logic flagZero,
	output logic flagOverflow,
	output logic flagNegative
);

	coreExecPkg::aluOp_t aluOp;
	logic [coreExecPkg::dataWidth-1:0] operandA;
	logic [coreExecPkg::dataWidth-1:0] operandB;
	logic [3:0] shiftAmount;
	logic [7:0] imm8;
	logic [coreExecPkg::dataWidth-1:0] aluResult;
	logic saturated;
	logic resultZero;

	regFileIf rfBus ();

	issueStage issue0 (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.rf(rfBus.issueSide),
		.aluOp(aluOp),
		.operandA(operandA),
		.operandB(operandB),
		.shiftAmount(shiftAmount),
		.imm8(imm8),
		.aluResult(aluResult),
		.saturated(saturated),
		.resultZero(resultZero),
		.resultValid(resultValid),
		.result(result),
		.resultDst(resultDst),
		.illegal(illegal),
		.flagZero(flagZero),
		.flagOverflow(flagOverflow),
		.flagNegative(flagNegative)
	);

	aluUnit alu0 (
		.aluOp(aluOp),
		.operandA(operandA),
		.operandB(operandB),
		.shiftAmount(shiftAmount),
		.imm8(imm8),
		.aluResult(aluResult),
		.saturated(saturated),
		.resultZero(resultZero)
	);

	registerFile regFile0 (
		.clk(clk),
		.reset(reset),
		.rf(rfBus.fileSide)
	);

endmodule

//--- verification/coreExecTb.sv
`timescale 1ns/1ps

module coreExecTb;

	logic clk;
	logic reset;
	logic instrValid;
	logic [15:0] instr;
	logic resultValid;
	logic [15:0] result;
	logic [3:0] resultDst;
	logic illegal;
	logic flagZero;
	logic flagOverflow;
	logic flagNegative;

	// {valid, illegal, zero, overflow, negative, dst, result}.
	logic [24:0] expStage0;
	logic [24:0] expStage1;
	logic [24:0] expStage2;
	logic [15:0] modelRegs [16];
	logic modelZero;
	logic modelOverflow;
	logic modelNegative;
	logic [3:0] ra;
	logic [3:0] rb;
	logic [3:0] rc;
	logic [3:0] chainOps [4];
	logic [3:0] badOps [8];

	coreExec dut0 (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.resultValid(resultValid),
		.result(result),
		.resultDst(resultDst),
		.illegal(illegal),
		.flagZero(flagZero),
		.flagOverflow(flagOverflow),
		.flagNegative(flagNegative)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// expected outputs follow the DUT two edges behind the stimulus.
	always_ff @(posedge clk) begin
		if (reset) begin
			expStage1 <= '0;
			expStage2 <= '0;
		end else begin
			expStage1 <= expStage0;
			expStage2 <= expStage1;
		end
	end

	task automatic stopRun();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic failPlain(input string what);
		$display("%s", what);
		stopRun();
	endtask

	task automatic failValue(input string name, input logic [15:0] got, input logic [15:0] exp);
		$display("Error: %s got %h expected %h", name, got, exp);
		stopRun();
	endtask

	unexpectedCheck: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> expStage2[24])
		else failPlain("resultValid rose with no instruction pending");
	missingCheck: assert property (@(posedge clk) disable iff (reset)
		expStage2[24] |-> resultValid)
		else failPlain("resultValid missing for an issued instruction");
	resultCheck: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> result == expStage2[15:0])
		else failValue("result", $sampled(result), $sampled(expStage2[15:0]));
	dstCheck: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> resultDst == expStage2[19:16])
		else failValue("resultDst", 16'($sampled(resultDst)), 16'($sampled(expStage2[19:16])));
	illegalCheck: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> illegal == expStage2[23])
		else failValue("illegal", 16'($sampled(illegal)), 16'($sampled(expStage2[23])));
	zeroCheck: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> flagZero == expStage2[22])
		else failValue("flagZero", 16'($sampled(flagZero)), 16'($sampled(expStage2[22])));
	overflowCheck: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> flagOverflow == expStage2[21])
		else failValue("flagOverflow", 16'($sampled(flagOverflow)), 16'($sampled(expStage2[21])));
	negativeCheck: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> flagNegative == expStage2[20])
		else failValue("flagNegative", 16'($sampled(flagNegative)), 16'($sampled(expStage2[20])));

	function automatic logic [15:0] satArith(input logic [15:0] a, input logic [15:0] b,
		input bit sub, output bit ovf);
		int sum;
		sum = sub ? int'($signed(a)) - int'($signed(b)) : int'($signed(a)) + int'($signed(b));
		ovf = (sum > 32767) || (sum < -32768);
		if (sum > 32767)
			return 16'h7fff;
		if (sum < -32768)
			return 16'h8000;
		return sum[15:0];
	endfunction

	function automatic logic [15:0] shiftLeftLogical(input logic [15:0] v, input logic [3:0] n);
		for (int i = 0; i < n; i++)
			v = {v[14:0], 1'b0};
		return v;
	endfunction

	function automatic logic [15:0] shiftRightArith(input logic [15:0] v, input logic [3:0] n);
		for (int i = 0; i < n; i++)
			v = {v[15], v[15:1]};
		return v;
	endfunction

	function automatic logic [15:0] rotateRight(input logic [15:0] v, input logic [3:0] n);
		for (int i = 0; i < n; i++)
			v = {v[0], v[15:1]};
		return v;
	endfunction

	// updates the model, then drives the word on the next rising edge.
	task automatic issueWord(input logic [15:0] word);
		logic [3:0] op;
		logic [3:0] rd;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		bit ill;
		bit ovf;
		op = word[15:12];
		rd = word[11:8];
		a = (op == coreExecPkg::opLlb || op == coreExecPkg::opLhb) ?
			modelRegs[rd] : modelRegs[word[7:4]];
		b = modelRegs[word[3:0]];
		ill = 1'b0;
		ovf = 1'b0;
		res = '0;
		case (op)
			coreExecPkg::opAdd: res = satArith(a, b, 1'b0, ovf);
			coreExecPkg::opSub: res = satArith(a, b, 1'b1, ovf);
			coreExecPkg::opXor: res = a ^ b;
			coreExecPkg::opSll: res = shiftLeftLogical(a, word[3:0]);
			coreExecPkg::opSra: res = shiftRightArith(a, word[3:0]);
			coreExecPkg::opRor: res = rotateRight(a, word[3:0]);
			coreExecPkg::opLlb: res = {a[15:8], word[7:0]};
			coreExecPkg::opLhb: res = {word[7:0], a[7:0]};
			default: ill = 1'b1;
		endcase
		if (!ill && op != coreExecPkg::opLlb && op != coreExecPkg::opLhb) begin
			modelZero = (res == 16'h0000);
			modelOverflow = ovf;
			modelNegative = (op == coreExecPkg::opAdd || op == coreExecPkg::opSub) && res[15];
		end
		if (!ill)
			modelRegs[rd] = res;
		@(posedge clk);
		instrValid <= 1'b1;
		instr <= word;
		expStage0 <= {1'b1, ill, modelZero, modelOverflow, modelNegative, rd, res};
	endtask

	task automatic loadConst(input logic [3:0] rd, input logic [15:0] value);
		issueWord({coreExecPkg::opLlb, rd, value[7:0]});
		issueWord({coreExecPkg::opLhb, rd, value[15:8]});
	endtask

	task automatic drain();
		int waited;
		@(posedge clk);
		instrValid <= 1'b0;
		expStage0 <= '0;
		waited = 0;
		while ((expStage0[24] || expStage1[24] || expStage2[24] || resultValid) && waited < 10) begin
			@(posedge clk);
			waited++;
		end
		if (waited >= 10)
			failPlain("results still pending 10 cycles after the last instruction");
	endtask

	initial begin
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		expStage0 = '0;
		modelZero = 1'b0;
		modelOverflow = 1'b0;
		modelNegative = 1'b0;
		for (int i = 0; i < 16; i++)
			modelRegs[i] = '0;
		chainOps = '{coreExecPkg::opAdd, coreExecPkg::opSub, coreExecPkg::opXor, coreExecPkg::opRor};
		badOps = '{4'd3, 4'd7, 4'd8, 4'd9, 4'd12, 4'd13, 4'd14, 4'd15};
		void'($urandom(32'h4152f500));
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		flagsClear: assert (!flagZero && !flagOverflow && !flagNegative)
			else failPlain("flags were not low after reset");

		for (int i = 0; i < 4; i++) begin
			ra = 4'($urandom_range(15, 0));
			rb = 4'($urandom_range(15, 0));
			rc = 4'($urandom_range(15, 0));
			issueWord({coreExecPkg::opXor, ra, rb, rc}); // cleared registers give zero.
		end
		drain();

		for (int r = 0; r < 16; r++)
			loadConst(4'(r), 16'($urandom));
		drain();

		loadConst(4'd1, 16'h4000 | 16'($urandom_range(16'h3fff, 0)));
		loadConst(4'd2, 16'h8000 | 16'($urandom_range(16'h3fff, 0)));
		issueWord({coreExecPkg::opAdd, 4'd3, 4'd1, 4'd1}); // positive overflow.
		issueWord({coreExecPkg::opAdd, 4'd4, 4'd2, 4'd2});
		issueWord({coreExecPkg::opSub, 4'd5, 4'd2, 4'd1});
		issueWord({coreExecPkg::opSub, 4'd6, 4'd1, 4'd2});
		for (int i = 0; i < 32; i++) begin
			ra = 4'($urandom_range(15, 0));
			rb = 4'($urandom_range(15, 0));
			rc = 4'($urandom_range(15, 0));
			issueWord({($urandom_range(1, 0) == 0) ? coreExecPkg::opAdd : coreExecPkg::opSub,
				ra, rb, rc});
		end
		drain();

		for (int amt = 0; amt < 16; amt++) begin
			rb = 4'($urandom_range(15, 0));
			issueWord({coreExecPkg::opSll, 4'd7, rb, 4'(amt)});
			issueWord({coreExecPkg::opSra, 4'd8, rb, 4'(amt)});
			issueWord({coreExecPkg::opRor, 4'd9, rb, 4'(amt)});
		end
		for (int i = 0; i < 16; i++) begin
			ra = 4'($urandom_range(15, 0));
			rb = 4'($urandom_range(15, 0));
			rc = 4'($urandom_range(15, 0));
			issueWord({coreExecPkg::opXor, ra, rb, rc});
		end
		drain();

		ra = 4'($urandom_range(15, 0));
		for (int i = 0; i < 12; i++) begin
			rb = 4'($urandom_range(15, 0));
			rc = 4'($urandom_range(15, 0));
			issueWord({chainOps[$urandom_range(3, 0)], rb, ra, rc}); // reads the last write.
			ra = rb;
		end
		drain();

		for (int i = 0; i < 8; i++) begin
			ra = 4'($urandom_range(15, 0));
			issueWord({badOps[i], ra, 8'($urandom)});
			issueWord({coreExecPkg::opAdd, ra + 4'd1, ra, ra});
		end
		drain();

		$display("all tests passed");
		$finish;
	end

endmodule

//--- verilog.f
design/coreExecPkg.sv
design/regFileIf.sv
design/registerFile.sv
design/aluUnit.sv
design/issueStage.sv
design/coreExec.sv
verification/coreExecTb.sv

//--- Makefile
BUILD = build

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -Mdir $(BUILD) --top-module coreExecTb -f verilog.f
	out=$$(./$(BUILD)/VcoreExecTb); echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf $(BUILD)
